//--- rtl/core_pkg.sv
/*
 * Shared widths, opcode constants and vector types for the out-of-order core.
 * Every RTL block imports this package inside its body.
 */
package core_pkg;

    //////////////////////////////
    // Sizes
    //////////////////////////////

    localparam int XLEN       = 32;
    localparam int NUM_REGS   = 8;
    localparam int ROB_DEPTH  = 8;
    localparam int RS_DEPTH   = 4;
    // Issue to CDB latency of the multiplier
    localparam int MUL_STAGES = 3;

    //////////////////////////////
    // Vector types
    //////////////////////////////

    typedef logic [XLEN-1:0] data_t;
    // Architectural register index
    typedef logic [2:0]      reg_idx_t;
    // ROB slot, doubles as the rename tag
    typedef logic [2:0]      rob_tag_t;
    typedef logic [2:0]      opcode_t;

    // Hardwired zero register
    localparam reg_idx_t ZERO_REG = 3'd0;

    // Opcodes
    localparam opcode_t OP_ADD = 3'd0;
    localparam opcode_t OP_SUB = 3'd1;
    localparam opcode_t OP_XOR = 3'd2;
    localparam opcode_t OP_MUL = 3'd3;
    // Load immediate, no source operands
    localparam opcode_t OP_LI  = 3'd4;

endpackage

//--- rtl/reg_map.sv
/*
 * Architectural register file with rename state. Each register carries
 * its committed value, a busy flag and the ROB tag of its last producer.
 * Renamed at dispatch, written at retirement.
 */
`timescale 1ns/1ps

module reg_map (
    input  logic               clock,
    input  logic               rst_n,
    input  logic               dispatch_fire,
    input  core_pkg::reg_idx_t inst_rd,
    input  core_pkg::reg_idx_t inst_rs1,
    input  core_pkg::reg_idx_t inst_rs2,
    input  core_pkg::rob_tag_t alloc_tag,
    input  logic               retire_valid,
    input  core_pkg::reg_idx_t retire_rd,
    input  core_pkg::rob_tag_t retire_tag,
    input  core_pkg::data_t    retire_value,
    output logic               src1_busy,
    output logic               src2_busy,
    output core_pkg::rob_tag_t src1_tag,
    output core_pkg::rob_tag_t src2_tag,
    output core_pkg::data_t    src1_value,
    output core_pkg::data_t    src2_value
);
    import core_pkg::*;

    data_t               regs [NUM_REGS];
    rob_tag_t            tags [NUM_REGS];
    logic [NUM_REGS-1:0] busy;

    // Source reads, register 0 is always zero and ready
    assign src1_busy  = (inst_rs1 != ZERO_REG) && busy[inst_rs1];
    assign src2_busy  = (inst_rs2 != ZERO_REG) && busy[inst_rs2];
    assign src1_tag   = tags[inst_rs1];
    assign src2_tag   = tags[inst_rs2];
    assign src1_value = (inst_rs1 == ZERO_REG) ? '0 : regs[inst_rs1];
    assign src2_value = (inst_rs2 == ZERO_REG) ? '0 : regs[inst_rs2];

    // Committed values and busy flags
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            busy <= '0;
            for (int r = 0; r < NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            if (retire_valid && retire_rd != ZERO_REG) begin
                regs[retire_rd] <= retire_value;
                // Only the newest producer frees the register
                if (tags[retire_rd] == retire_tag) begin
                    busy[retire_rd] <= 1'b0;
                end
            end
            // Same-cycle rename wins over the retire clear
            if (dispatch_fire && inst_rd != ZERO_REG) begin
                busy[inst_rd] <= 1'b1;
            end
        end
    end

    // Rename tags, meaningful only while busy
    always_ff @(posedge clock) begin
        if (dispatch_fire && inst_rd != ZERO_REG) begin
            tags[inst_rd] <= alloc_tag;
        end
    end

endmodule

//--- rtl/reorder_buffer.sv
/*
 * Eight-entry circular reorder buffer. Allocates the tail at dispatch,
 * marks entries done from the CDB, answers operand lookups and retires
 * the head in program order once it is done.
 */
`timescale 1ns/1ps

module reorder_buffer (
    input  logic               clock,
    input  logic               rst_n,
    input  logic               dispatch_fire,
    input  core_pkg::reg_idx_t inst_rd,
    output logic               rob_ready,
    output core_pkg::rob_tag_t alloc_tag,
    input  core_pkg::rob_tag_t lookup1_tag,
    input  core_pkg::rob_tag_t lookup2_tag,
    output logic               lookup1_done,
    output logic               lookup2_done,
    output core_pkg::data_t    lookup1_value,
    output core_pkg::data_t    lookup2_value,
    input  logic               cdb_valid,
    input  core_pkg::rob_tag_t cdb_tag,
    input  core_pkg::data_t    cdb_value,
    output logic               retire_valid,
    output core_pkg::reg_idx_t retire_rd,
    output core_pkg::rob_tag_t retire_tag,
    output core_pkg::data_t    retire_value,
    output logic               commit_wr_en
);
    import core_pkg::*;

    rob_tag_t                     head;
    rob_tag_t                     tail;
    logic [$clog2(ROB_DEPTH):0]   count;
    logic [ROB_DEPTH-1:0]         done;
    reg_idx_t                     dest [ROB_DEPTH];
    data_t                        value [ROB_DEPTH];

    //////////////////////////////
    // Dispatch and lookups
    //////////////////////////////

    // Full check on registered count only
    assign rob_ready = (count != ROB_DEPTH);
    assign alloc_tag = tail;

    assign lookup1_done  = done[lookup1_tag];
    assign lookup2_done  = done[lookup2_tag];
    assign lookup1_value = value[lookup1_tag];
    assign lookup2_value = value[lookup2_tag];

    //////////////////////////////
    // Retire
    //////////////////////////////

    // Stale done bits of free slots masked by count
    assign retire_valid = (count != '0) && done[head];
    assign retire_rd    = dest[head];
    assign retire_tag   = head;
    assign retire_value = value[head];
    assign commit_wr_en = retire_valid && (dest[head] != ZERO_REG);

    // Pointers, occupancy and done flags
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            done  <= '0;
        end else begin
            if (cdb_valid) begin
                done[cdb_tag] <= 1'b1;
            end
            if (dispatch_fire) begin
                done[tail] <= 1'b0;
                tail       <= tail + 1'b1;
            end
            if (retire_valid) begin
                head <= head + 1'b1;
            end
            case ({dispatch_fire, retire_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Entry payload
    always_ff @(posedge clock) begin
        if (dispatch_fire) begin
            dest[tail] <= inst_rd;
        end
        if (cdb_valid) begin
            value[cdb_tag] <= cdb_value;
        end
    end

endmodule

//--- rtl/res_station.sv
/*
 * Shared reservation station of four entries. Captures operands at
 * dispatch from the register map, the ROB or the CDB, wakes waiting
 * entries from the CDB and issues the lowest ready entry to each unit.
 */
`timescale 1ns/1ps

module res_station (
    input  logic               clock,
    input  logic               rst_n,
    input  logic               dispatch_fire,
    input  core_pkg::opcode_t  inst_op,
    input  core_pkg::data_t    inst_imm,
    input  core_pkg::rob_tag_t alloc_tag,
    input  logic               src1_busy,
    input  logic               src2_busy,
    input  core_pkg::rob_tag_t src1_tag,
    input  core_pkg::rob_tag_t src2_tag,
    input  core_pkg::data_t    src1_value,
    input  core_pkg::data_t    src2_value,
    input  logic               lookup1_done,
    input  logic               lookup2_done,
    input  core_pkg::data_t    lookup1_value,
    input  core_pkg::data_t    lookup2_value,
    input  logic               cdb_valid,
    input  core_pkg::rob_tag_t cdb_tag,
    input  core_pkg::data_t    cdb_value,
    input  logic               alu_busy,
    output logic               rs_ready,
    output logic               alu_issue,
    output logic               mul_issue,
    output core_pkg::opcode_t  alu_op,
    output core_pkg::data_t    alu_a,
    output core_pkg::data_t    alu_b,
    output core_pkg::data_t    alu_imm,
    output core_pkg::rob_tag_t alu_tag,
    output core_pkg::data_t    mul_a,
    output core_pkg::data_t    mul_b,
    output core_pkg::rob_tag_t mul_tag
);
    import core_pkg::*;

    // Entry state
    logic [RS_DEPTH-1:0] ent_valid;
    logic [RS_DEPTH-1:0] ent_rdy1;
    logic [RS_DEPTH-1:0] ent_rdy2;
    logic [RS_DEPTH-1:0] ent_ready;
    opcode_t             ent_op  [RS_DEPTH];
    data_t               ent_imm [RS_DEPTH];
    rob_tag_t            ent_tag [RS_DEPTH];
    rob_tag_t            ent_q1  [RS_DEPTH];
    rob_tag_t            ent_q2  [RS_DEPTH];
    data_t               ent_v1  [RS_DEPTH];
    data_t               ent_v2  [RS_DEPTH];

    logic [$clog2(RS_DEPTH)-1:0] free_idx;
    logic [$clog2(RS_DEPTH)-1:0] alu_idx;
    logic [$clog2(RS_DEPTH)-1:0] mul_idx;

    // Captured operands for the dispatching entry
    logic  cap_rdy1;
    logic  cap_rdy2;
    data_t cap_v1;
    data_t cap_v2;

    // Register map, then ROB, then a CDB hit this cycle
    function automatic void resolve(input logic busy, input rob_tag_t tag, input data_t rf_val,
                                    input logic rob_done, input data_t rob_val,
                                    output logic rdy, output data_t val);
        rdy = 1'b1;
        val = rf_val;
        if (busy) begin
            if (rob_done) begin
                val = rob_val;
            end else if (cdb_valid && cdb_tag == tag) begin
                val = cdb_value;
            end else begin
                rdy = 1'b0;
            end
        end
    endfunction

    always_comb begin
        resolve(src1_busy, src1_tag, src1_value, lookup1_done, lookup1_value, cap_rdy1, cap_v1);
        resolve(src2_busy, src2_tag, src2_value, lookup2_done, lookup2_value, cap_rdy2, cap_v2);
        // LI reads no sources
        if (inst_op == OP_LI) begin
            cap_rdy1 = 1'b1;
            cap_rdy2 = 1'b1;
        end
    end

    //////////////////////////////
    // Free slot and issue select
    //////////////////////////////

    assign rs_ready  = ~&ent_valid;
    assign ent_ready = ent_valid & ent_rdy1 & ent_rdy2;

    // Downward scan so the lowest index wins
    always_comb begin
        free_idx  = '0;
        alu_idx   = '0;
        mul_idx   = '0;
        alu_issue = 1'b0;
        mul_issue = 1'b0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (!ent_valid[i]) begin
                free_idx = i[$clog2(RS_DEPTH)-1:0];
            end
            if (ent_ready[i] && ent_op[i] == OP_MUL) begin
                mul_idx   = i[$clog2(RS_DEPTH)-1:0];
                mul_issue = 1'b1;
            end
            if (ent_ready[i] && ent_op[i] != OP_MUL && !alu_busy) begin
                alu_idx   = i[$clog2(RS_DEPTH)-1:0];
                alu_issue = 1'b1;
            end
        end
    end

    // Separate operand sets, both units may issue together
    assign alu_op  = ent_op[alu_idx];
    assign alu_a   = ent_v1[alu_idx];
    assign alu_b   = ent_v2[alu_idx];
    assign alu_imm = ent_imm[alu_idx];
    assign alu_tag = ent_tag[alu_idx];
    assign mul_a   = ent_v1[mul_idx];
    assign mul_b   = ent_v2[mul_idx];
    assign mul_tag = ent_tag[mul_idx];

    //////////////////////////////
    // Entry update
    //////////////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            ent_valid <= '0;
            ent_rdy1  <= '0;
            ent_rdy2  <= '0;
        end else begin
            // CDB wakeup
            for (int i = 0; i < RS_DEPTH; i++) begin
                if (cdb_valid && !ent_rdy1[i] && ent_q1[i] == cdb_tag) begin
                    ent_rdy1[i] <= 1'b1;
                end
                if (cdb_valid && !ent_rdy2[i] && ent_q2[i] == cdb_tag) begin
                    ent_rdy2[i] <= 1'b1;
                end
            end
            if (alu_issue) begin
                ent_valid[alu_idx] <= 1'b0;
            end
            if (mul_issue) begin
                ent_valid[mul_idx] <= 1'b0;
            end
            // Free slot is never the one issuing
            if (dispatch_fire) begin
                ent_valid[free_idx] <= 1'b1;
                ent_rdy1[free_idx]  <= cap_rdy1;
                ent_rdy2[free_idx]  <= cap_rdy2;
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (cdb_valid && !ent_rdy1[i] && ent_q1[i] == cdb_tag) begin
                ent_v1[i] <= cdb_value;
            end
            if (cdb_valid && !ent_rdy2[i] && ent_q2[i] == cdb_tag) begin
                ent_v2[i] <= cdb_value;
            end
        end
        if (dispatch_fire) begin
            ent_op[free_idx]  <= inst_op;
            ent_imm[free_idx] <= inst_imm;
            ent_tag[free_idx] <= alloc_tag;
            ent_q1[free_idx]  <= src1_tag;
            ent_q2[free_idx]  <= src2_tag;
            ent_v1[free_idx]  <= cap_v1;
            ent_v2[free_idx]  <= cap_v2;
        end
    end

endmodule

//--- rtl/alu_unit.sv
/*
 * Single-cycle ALU for ADD, SUB, XOR and LI. The result is registered
 * and held until the CDB arbiter grants it; busy blocks new issue.
 */
`timescale 1ns/1ps

module alu_unit (
    input  logic               clock,
    input  logic               rst_n,
    input  logic               alu_issue,
    input  core_pkg::opcode_t  iss_op,
    input  core_pkg::data_t    iss_a,
    input  core_pkg::data_t    iss_b,
    input  core_pkg::data_t    iss_imm,
    input  core_pkg::rob_tag_t iss_tag,
    input  logic               alu_grant,
    output logic               alu_result_valid,
    output core_pkg::rob_tag_t alu_tag,
    output core_pkg::data_t    alu_value,
    output logic               alu_busy
);
    import core_pkg::*;

    data_t result;

    always_comb begin
        case (iss_op)
            OP_ADD:  result = iss_a + iss_b;
            OP_SUB:  result = iss_a - iss_b;
            OP_XOR:  result = iss_a ^ iss_b;
            OP_LI:   result = iss_imm;
            default: result = '0;
        endcase
    end

    // Held result not yet on the bus
    assign alu_busy = alu_result_valid && !alu_grant;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            alu_result_valid <= 1'b0;
        end else if (alu_issue) begin
            alu_result_valid <= 1'b1;
        end else if (alu_grant) begin
            alu_result_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (alu_issue) begin
            alu_tag   <= iss_tag;
            alu_value <= result;
        end
    end

endmodule

//--- rtl/mul_unit.sv
/*
 * Pipelined multiplier, MUL_STAGES deep, low word of the product.
 * Accepts one operation per cycle and never stalls.
 */
`timescale 1ns/1ps

module mul_unit (
    input  logic               clock,
    input  logic               rst_n,
    input  logic               mul_issue,
    input  core_pkg::data_t    mul_a,
    input  core_pkg::data_t    mul_b,
    input  core_pkg::rob_tag_t mul_tag_in,
    output logic               mul_result_valid,
    output core_pkg::rob_tag_t mul_tag,
    output core_pkg::data_t    mul_value
);
    import core_pkg::*;

    logic [MUL_STAGES-1:0] stg_valid;
    rob_tag_t              stg_tag  [MUL_STAGES];
    data_t                 stg_prod [MUL_STAGES];

    // Valid shift chain
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            stg_valid <= '0;
        end else begin
            stg_valid <= {stg_valid[MUL_STAGES-2:0], mul_issue};
        end
    end

    // Product formed in the first stage, carried through the rest
    always_ff @(posedge clock) begin
        stg_prod[0] <= mul_a * mul_b;
        stg_tag[0]  <= mul_tag_in;
        for (int s = 1; s < MUL_STAGES; s++) begin
            stg_prod[s] <= stg_prod[s-1];
            stg_tag[s]  <= stg_tag[s-1];
        end
    end

    assign mul_result_valid = stg_valid[MUL_STAGES-1];
    assign mul_tag          = stg_tag[MUL_STAGES-1];
    assign mul_value        = stg_prod[MUL_STAGES-1];

endmodule

//--- rtl/cdb_arbiter.sv
/*
 * Common data bus arbiter. The multiplier cannot stall, so its result
 * always wins; the ALU holds its result until granted.
 */
`timescale 1ns/1ps

module cdb_arbiter (
    input  logic               alu_result_valid,
    input  core_pkg::rob_tag_t alu_tag,
    input  core_pkg::data_t    alu_value,
    input  logic               mul_result_valid,
    input  core_pkg::rob_tag_t mul_tag,
    input  core_pkg::data_t    mul_value,
    output logic               alu_grant,
    output logic               cdb_valid,
    output core_pkg::rob_tag_t cdb_tag,
    output core_pkg::data_t    cdb_value
);
    import core_pkg::*;

    // ALU only gets a free bus cycle
    assign alu_grant = alu_result_valid && !mul_result_valid;
    assign cdb_valid = alu_result_valid || mul_result_valid;
    assign cdb_tag   = mul_result_valid ? mul_tag : alu_tag;
    assign cdb_value = mul_result_valid ? mul_value : alu_value;

endmodule

//--- rtl/ooo_core.sv
/*
 * Top of the Tomasulo-style core. Takes decoded instructions on a
 * valid/ready dispatch port and reports in-order retirement on the
 * commit port. Wiring only, all logic sits in the child blocks.
 */
`timescale 1ns/1ps

module ooo_core (
    input  logic               clock,
    input  logic               rst_n,
    input  logic               inst_valid,
    output logic               inst_ready,
    input  core_pkg::opcode_t  inst_op,
    input  core_pkg::reg_idx_t inst_rd,
    input  core_pkg::reg_idx_t inst_rs1,
    input  core_pkg::reg_idx_t inst_rs2,
    input  core_pkg::data_t    inst_imm,
    output logic               commit_valid,
    output logic               commit_wr_en,
    output core_pkg::reg_idx_t commit_idx,
    output core_pkg::data_t    commit_data
);
    import core_pkg::*;

    // Dispatch handshake
    logic     rob_ready;
    logic     rs_ready;
    rob_tag_t alloc_tag;
    assign inst_ready = rob_ready && rs_ready;
    wire dispatch_fire = inst_valid && inst_ready;

    // Register map and ROB lookup results
    logic     src1_busy;
    logic     src2_busy;
    rob_tag_t src1_tag;
    rob_tag_t src2_tag;
    data_t    src1_value;
    data_t    src2_value;
    logic     lookup1_done;
    logic     lookup2_done;
    data_t    lookup1_value;
    data_t    lookup2_value;
    rob_tag_t retire_tag;

    // Issue side
    logic     alu_issue;
    logic     mul_issue;
    logic     alu_busy;
    opcode_t  iss_op;
    data_t    iss_a;
    data_t    iss_b;
    data_t    iss_imm;
    rob_tag_t iss_tag;
    data_t    mul_a;
    data_t    mul_b;
    rob_tag_t mul_tag_in;

    // Results and the common data bus
    logic     alu_result_valid;
    logic     alu_grant;
    rob_tag_t alu_tag;
    data_t    alu_value;
    logic     mul_result_valid;
    rob_tag_t mul_tag;
    data_t    mul_value;
    logic     cdb_valid;
    rob_tag_t cdb_tag;
    data_t    cdb_value;

    reg_map u_reg_map (
        .clock(clock), .rst_n(rst_n), .dispatch_fire(dispatch_fire),
        .inst_rd(inst_rd), .inst_rs1(inst_rs1), .inst_rs2(inst_rs2), .alloc_tag(alloc_tag),
        .retire_valid(commit_valid), .retire_rd(commit_idx), .retire_tag(retire_tag),
        .retire_value(commit_data),
        .src1_busy(src1_busy), .src2_busy(src2_busy), .src1_tag(src1_tag),
        .src2_tag(src2_tag), .src1_value(src1_value), .src2_value(src2_value)
    );

    reorder_buffer u_rob (
        .clock(clock), .rst_n(rst_n), .dispatch_fire(dispatch_fire), .inst_rd(inst_rd),
        .rob_ready(rob_ready), .alloc_tag(alloc_tag),
        .lookup1_tag(src1_tag), .lookup2_tag(src2_tag),
        .lookup1_done(lookup1_done), .lookup2_done(lookup2_done),
        .lookup1_value(lookup1_value), .lookup2_value(lookup2_value),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value),
        .retire_valid(commit_valid), .retire_rd(commit_idx), .retire_tag(retire_tag),
        .retire_value(commit_data), .commit_wr_en(commit_wr_en)
    );

    res_station u_rs (
        .clock(clock), .rst_n(rst_n), .dispatch_fire(dispatch_fire),
        .inst_op(inst_op), .inst_imm(inst_imm), .alloc_tag(alloc_tag),
        .src1_busy(src1_busy), .src2_busy(src2_busy), .src1_tag(src1_tag),
        .src2_tag(src2_tag), .src1_value(src1_value), .src2_value(src2_value),
        .lookup1_done(lookup1_done), .lookup2_done(lookup2_done),
        .lookup1_value(lookup1_value), .lookup2_value(lookup2_value),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value),
        .alu_busy(alu_busy), .rs_ready(rs_ready),
        .alu_issue(alu_issue), .mul_issue(mul_issue),
        .alu_op(iss_op), .alu_a(iss_a), .alu_b(iss_b), .alu_imm(iss_imm), .alu_tag(iss_tag),
        .mul_a(mul_a), .mul_b(mul_b), .mul_tag(mul_tag_in)
    );

    alu_unit u_alu (
        .clock(clock), .rst_n(rst_n), .alu_issue(alu_issue),
        .iss_op(iss_op), .iss_a(iss_a), .iss_b(iss_b), .iss_imm(iss_imm), .iss_tag(iss_tag),
        .alu_grant(alu_grant), .alu_result_valid(alu_result_valid),
        .alu_tag(alu_tag), .alu_value(alu_value), .alu_busy(alu_busy)
    );

    mul_unit u_mul (
        .clock(clock), .rst_n(rst_n), .mul_issue(mul_issue),
        .mul_a(mul_a), .mul_b(mul_b), .mul_tag_in(mul_tag_in),
        .mul_result_valid(mul_result_valid), .mul_tag(mul_tag), .mul_value(mul_value)
    );

    cdb_arbiter u_cdb (
        .alu_result_valid(alu_result_valid), .alu_tag(alu_tag), .alu_value(alu_value),
        .mul_result_valid(mul_result_valid), .mul_tag(mul_tag), .mul_value(mul_value),
        .alu_grant(alu_grant),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value)
    );

endmodule

//--- test/tb_ooo_core.sv
/*
 * Testbench for the out-of-order core. Applies a table of decoded
 * instructions on the dispatch port with random idle gaps. Checks every
 * commit against an in-order reference register file.
 */
`timescale 1ns/1ps

module tb_ooo_core;
    import core_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 16;

    // DUT ports
    logic     clock;
    logic     rst_n;
    logic     inst_valid;
    logic     inst_ready;
    opcode_t  inst_op;
    reg_idx_t inst_rd;
    reg_idx_t inst_rs1;
    reg_idx_t inst_rs2;
    data_t    inst_imm;
    logic     commit_valid;
    logic     commit_wr_en;
    reg_idx_t commit_idx;
    data_t    commit_data;

    // Instruction table with one slot per entry
    string    t_name  [$];
    opcode_t  t_op    [$];
    reg_idx_t t_rd    [$];
    reg_idx_t t_rs1   [$];
    reg_idx_t t_rs2   [$];
    data_t    t_imm   [$];
    logic     t_tight [$];

    // Expected commit stream
    reg_idx_t exp_idx  [$];
    data_t    exp_data [$];
    logic     exp_wr   [$];

    data_t       ref_regs [NUM_REGS];
    logic [31:0] rng_state;
    int          cycle_count;
    int          cycle_limit;
    int          commit_count;
    logic        burst_stalled;

    ooo_core DUT (
        .clock(clock), .rst_n(rst_n),
        .inst_valid(inst_valid), .inst_ready(inst_ready), .inst_op(inst_op),
        .inst_rd(inst_rd), .inst_rs1(inst_rs1), .inst_rs2(inst_rs2), .inst_imm(inst_imm),
        .commit_valid(commit_valid), .commit_wr_en(commit_wr_en),
        .commit_idx(commit_idx), .commit_data(commit_data)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (act !== exp) begin
            abort_run($sformatf("Mismatch in %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_idx(input string name, input reg_idx_t exp, input reg_idx_t act);
        if (act !== exp) begin
            abort_run($sformatf("Mismatch in %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("Mismatch in %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    function automatic void add_inst(input string name, input opcode_t op, input reg_idx_t rd,
                                     input reg_idx_t rs1, input reg_idx_t rs2,
                                     input data_t imm, input logic tight);
        t_name.push_back(name);
        t_op.push_back(op);
        t_rd.push_back(rd);
        t_rs1.push_back(rs1);
        t_rs2.push_back(rs2);
        t_imm.push_back(imm);
        t_tight.push_back(tight);
    endfunction

    //////////////////////////////
    // Stimulus table
    //////////////////////////////

    function automatic void build_table();
        // Independent ALU ops
        add_inst("li_r1", OP_LI, 3'd1, 3'd0, 3'd0, 32'h0000_1234, 1'b0);
        add_inst("li_r2", OP_LI, 3'd2, 3'd0, 3'd0, 32'h0000_0f0f, 1'b0);
        add_inst("li_r3", OP_LI, 3'd3, 3'd0, 3'd0, 32'hffff_fff0, 1'b0);
        add_inst("add_r4", OP_ADD, 3'd4, 3'd1, 3'd2, 32'h0, 1'b0);
        add_inst("sub_r5", OP_SUB, 3'd5, 3'd1, 3'd3, 32'h0, 1'b0);
        add_inst("xor_r6", OP_XOR, 3'd6, 3'd2, 3'd3, 32'h0, 1'b0);
        add_inst("li_r7", OP_LI, 3'd7, 3'd0, 3'd0, 32'h8000_0001, 1'b0);
        // MUL feeding dependent ops and another MUL
        add_inst("mul_r1", OP_MUL, 3'd1, 3'd2, 3'd7, 32'h0, 1'b0);
        add_inst("add_dep1", OP_ADD, 3'd2, 3'd1, 3'd1, 32'h0, 1'b0);
        add_inst("add_dep2", OP_ADD, 3'd3, 3'd2, 3'd4, 32'h0, 1'b0);
        add_inst("mul_dep", OP_MUL, 3'd4, 3'd1, 3'd3, 32'h0, 1'b0);
        add_inst("mul_mul", OP_MUL, 3'd5, 3'd4, 3'd4, 32'h0, 1'b0);
        add_inst("sub_late", OP_SUB, 3'd6, 3'd5, 3'd1, 32'h0, 1'b0);
        // Long MUL overtaken by younger ALU ops
        add_inst("mul_long", OP_MUL, 3'd6, 3'd5, 3'd4, 32'h0, 1'b0);
        add_inst("li_fast", OP_LI, 3'd7, 3'd0, 3'd0, 32'h0000_0055, 1'b0);
        add_inst("xor_fast", OP_XOR, 3'd3, 3'd7, 3'd2, 32'h0, 1'b0);
        add_inst("add_fast", OP_ADD, 3'd1, 3'd3, 3'd7, 32'h0, 1'b0);
        add_inst("sub_tail", OP_SUB, 3'd2, 3'd6, 3'd7, 32'h0, 1'b0);
        // Gapless burst past ROB_DEPTH
        for (int k = 0; k < 12; k++) begin
            case (k % 3)
                0: add_inst($sformatf("burst_%0d", k), OP_MUL, 3'd1, 3'd1, 3'd2,
                            32'h0, 1'b1);
                1: add_inst($sformatf("burst_%0d", k), OP_ADD, 3'd2, 3'd1, 3'd7,
                            32'h0, 1'b1);
                default: add_inst($sformatf("burst_%0d", k), OP_LI, 3'd7, 3'd0, 3'd0,
                                  32'h1357_0000 + k, 1'b1);
            endcase
        end
        // Register 0 stays zero
        add_inst("li_r0", OP_LI, 3'd0, 3'd0, 3'd0, 32'hdead_beef, 1'b0);
        add_inst("add_r0", OP_ADD, 3'd0, 3'd1, 3'd2, 32'h0, 1'b0);
        add_inst("read_r0", OP_ADD, 3'd3, 3'd0, 3'd0, 32'h0, 1'b0);
        add_inst("xor_r0", OP_XOR, 3'd4, 3'd0, 3'd5, 32'h0, 1'b0);
        add_inst("mul_r0", OP_MUL, 3'd5, 3'd0, 3'd6, 32'h0, 1'b0);
    endfunction

    //////////////////////////////
    // Reference model
    //////////////////////////////

    function automatic data_t expected_result(input opcode_t op, input data_t a, input data_t b,
                                              input data_t imm);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_XOR:  return a ^ b;
            // Low word of the product
            OP_MUL:  return a * b;
            OP_LI:   return imm;
            default: return '0;
        endcase
    endfunction

    // In-order execution of the whole table
    function automatic void build_expected();
        data_t a;
        data_t b;
        data_t v;
        for (int r = 0; r < NUM_REGS; r++) begin
            ref_regs[r] = '0;
        end
        for (int i = 0; i < t_name.size(); i++) begin
            a = (t_rs1[i] == ZERO_REG) ? '0 : ref_regs[t_rs1[i]];
            b = (t_rs2[i] == ZERO_REG) ? '0 : ref_regs[t_rs2[i]];
            v = expected_result(t_op[i], a, b, t_imm[i]);
            exp_idx.push_back(t_rd[i]);
            exp_data.push_back(v);
            exp_wr.push_back(t_rd[i] != ZERO_REG);
            if (t_rd[i] != ZERO_REG) begin
                ref_regs[t_rd[i]] = v;
            end
        end
    endfunction

    // Drive at the current rising edge and return on the accepting edge
    task automatic dispatch_one(input int idx);
        logic accepted;
        inst_valid <= 1'b1;
        inst_op    <= t_op[idx];
        inst_rd    <= t_rd[idx];
        inst_rs1   <= t_rs1[idx];
        inst_rs2   <= t_rs2[idx];
        inst_imm   <= t_imm[idx];
        accepted = 1'b0;
        while (!accepted) begin
            // Ready comes from registered state and is stable by mid-cycle
            @(negedge clock);
            accepted = inst_ready;
            if (!accepted && t_tight[idx]) begin
                burst_stalled = 1'b1;
            end
            @(posedge clock);
        end
    endtask

    //////////////////////////////
    // Commit monitor and timeout
    //////////////////////////////

    always @(negedge clock) begin
        if (rst_n && commit_valid) begin
            if (commit_count >= exp_idx.size()) begin
                abort_run("Commit seen after every table entry had already committed");
            end else begin
                check_idx({t_name[commit_count], " commit_idx"}, exp_idx[commit_count],
                          commit_idx);
                check_bit({t_name[commit_count], " commit_wr_en"}, exp_wr[commit_count],
                          commit_wr_en);
                check_data({t_name[commit_count], " commit_data"}, exp_data[commit_count],
                           commit_data);
                commit_count++;
            end
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            abort_run($sformatf("Timeout after %0d cycles with %0d of %0d commits seen",
                                cycle_count, commit_count, exp_idx.size()));
        end
    end

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        int gap;
        rst_n         = 1'b0;
        inst_valid    = 1'b0;
        inst_op       = OP_ADD;
        inst_rd       = '0;
        inst_rs1      = '0;
        inst_rs2      = '0;
        inst_imm      = '0;
        rng_state     = 32'h3199_0f3c;
        cycle_count   = 0;
        commit_count  = 0;
        burst_stalled = 1'b0;
        build_table();
        build_expected();
        cycle_limit = 20 * t_name.size() + 100;

        repeat (RESET_CYCLES) @(posedge clock);
        rst_n <= 1'b1;
        @(negedge clock);
        check_bit("reset commit_valid", 1'b0, commit_valid);
        check_bit("reset commit_wr_en", 1'b0, commit_wr_en);
        check_bit("reset inst_ready", 1'b1, inst_ready);
        @(posedge clock);

        for (int i = 0; i < t_name.size(); i++) begin
            // Idle gaps only outside the burst
            if (!t_tight[i]) begin
                rng_state = next_random(rng_state);
                gap = int'(rng_state % 3);
                if (gap > 0) begin
                    inst_valid <= 1'b0;
                    repeat (gap) @(posedge clock);
                end
            end
            dispatch_one(i);
        end
        inst_valid <= 1'b0;

        while (commit_count < exp_idx.size()) begin
            @(posedge clock);
        end
        // Quiet window to catch duplicate commits
        repeat (10) @(posedge clock);
        check_bit("burst back-pressure on inst_ready", 1'b1, burst_stalled);

        $display("TESTS PASSED");
        $finish;
    end

endmodule

//--- sim.f
rtl/core_pkg.sv
rtl/reg_map.sv
rtl/reorder_buffer.sv
rtl/res_station.sv
rtl/alu_unit.sv
rtl/mul_unit.sv
rtl/cdb_arbiter.sv
rtl/ooo_core.sv
test/tb_ooo_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the core testbench with Verilator, run it, and judge the result from the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ_DIR=obj_dir

verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_ooo_core \
    --Mdir "$OBJ_DIR" -o tb_ooo_core_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ_DIR/tb_ooo_core_sim" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "TESTS FAILED" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi
exit 0
